// File: Makefile
# Verilator build and run of the norm check testbench
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run into $(LOG), fail on a failed result"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module norm_check_tb -Mdir $(OBJ_DIR) -o norm_check_sim
	@./$(OBJ_DIR)/norm_check_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/mldsa_types_pkg.sv
// Vector types shared by the coefficient memory and the norm check
// Lane 0 of a memory word sits in the least significant bits

`include "norm_check_consts.svh"

package mldsa_types_pkg;

    // One coefficient modulo q
    typedef logic [`NC_COEF_W-1:0] coef_t;

    // Word address into the coefficient memory
    typedef logic [`NC_ADDR_W-1:0] mem_addr_t;

    // Four packed coefficients, one memory word
    typedef logic [`NC_LANES*`NC_COEF_W-1:0] mem_word_t;

    // Seed for the read-order shuffle
    typedef logic [`NC_RAND_W-1:0] rand_t;

endpackage

// File: common/norm_check_consts.svh
// Field and bound constants for the ML-DSA norm check
// Coefficients in memory are assumed fully reduced, that is below NC_Q
// One polynomial fills NC_N / NC_LANES consecutive memory words
`ifndef NORM_CHECK_CONSTS_SVH
`define NORM_CHECK_CONSTS_SVH

// Prime modulus and polynomial size of ML-DSA
`define NC_Q 8380417
`define NC_N 256

// Storage layout, four coefficients share one memory word
`define NC_COEF_W 23
`define NC_LANES 4
`define NC_ADDR_W 10
`define NC_WORDS_PER_POLY (`NC_N / `NC_LANES)

// Width of the read-order shuffle seed
`define NC_RAND_W 6

// Scheme parameters of the supported parameter set
`define NC_GAMMA1 (1 << 19)
`define NC_GAMMA2 261888
`define NC_BETA 120

// Largest value that still counts as positive in centered form
`define NC_HALF_Q ((`NC_Q - 1) / 2)

// A coefficient fails when its centered magnitude reaches the bound
`define NC_BOUND_Z (`NC_GAMMA1 - `NC_BETA)
`define NC_BOUND_R0 (`NC_GAMMA2 - `NC_BETA)
`define NC_BOUND_CT0 (`NC_GAMMA2)

`endif

// File: common/norm_check_pkg.sv
// Enumerations of the norm check block
// Mode encoding 2'd3 is unused and falls back to the ct0 bound

package norm_check_pkg;

    // Which bound the polynomial is checked against
    typedef enum logic [1:0] {
        CHK_Z   = 2'd0,
        CHK_R0  = 2'd1,
        CHK_CT0 = 2'd2
    } chk_norm_mode_e;

    // Read sequencing of the controller
    typedef enum logic [1:0] {
        CHK_IDLE   = 2'd0,
        CHK_RD_MEM = 2'd1,
        CHK_WAIT   = 2'd2,
        CHK_DONE   = 2'd3
    } chk_read_state_e;

endpackage

// File: dv/norm_check_checker.sv
// Watches the norm check outputs and expects done 66 cycles after the enable edge
// Samples on the rising edge while the testbench drives on the falling edge
`timescale 1ns/10ps

module norm_check_checker (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize,
    input  logic            norm_check_enable,
    input  logic [8*32-1:0] test_name,
    input  logic            expect_invalid,
    input  logic            norm_invalid,
    input  logic            done,
    output int              error_count,
    output int              check_count
);

    localparam int DONE_LATENCY = 66;

    logic busy;
    int   cycles;
    logic held_value;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clk) begin
        if (!reset_n) begin
            busy       = 1'b0;
            cycles     = 0;
            held_value = 1'b0;
        end else if (zeroize) begin
            // The flag is cleared by the same edge
            busy       = 1'b0;
            held_value = 1'b0;
        end else if (norm_check_enable) begin
            busy   = 1'b1;
            cycles = 0;
        end else if (busy) begin
            cycles++;
            if (cycles == 1 && norm_invalid !== 1'b0) begin
                $display("norm_invalid was not cleared by the enable of %0s", test_name);
                error_count++;
            end
            if (done === 1'b1) begin
                if (cycles != DONE_LATENCY) begin
                    $display("done of %0s came %0d cycles after the enable, not %0d",
                             test_name, cycles, DONE_LATENCY);
                    error_count++;
                end
                if (norm_invalid !== expect_invalid) begin
                    $display("ERR %0s expected=%0d actual=%0d",
                             test_name, expect_invalid, norm_invalid);
                    error_count++;
                end
                check_count++;
                held_value = norm_invalid;
                busy       = 1'b0;
            end else if (cycles == DONE_LATENCY) begin
                $display("done of %0s is missing at cycle %0d", test_name, DONE_LATENCY);
                error_count++;
                held_value = norm_invalid;
                busy       = 1'b0;
            end
        end else begin
            if (done !== 1'b0) begin
                $display("Spurious done while no check was running, after %0s", test_name);
                error_count++;
            end
            // norm_invalid must hold its last result until the next enable
            if (norm_invalid !== held_value) begin
                $display("norm_invalid changed while idle after %0s", test_name);
                error_count++;
                held_value = norm_invalid;
            end
        end
    end

endmodule

// File: dv/norm_check_stimulus.txt
# name mode rand(hex) base(hex) fill idx value(decimal) expect abort_cycle
# fill 0 small, 1 up to bound-1, 2 keep memory; idx -1 none, 256 word after region
z_clean        0 00 000 0  -1       0 0  0
r0_clean       1 15 040 1  -1       0 0  0
ct0_clean      2 3a 080 1  -1       0 0  0
z_pos_at       0 07 100 1   5  524168 1  0
z_pos_below    0 07 100 1   5  524167 0  0
z_neg_at       0 21 100 1  17 7856249 1  0
z_neg_below    0 21 100 1  17 7856250 0  0
r0_pos_at      1 09 140 1  42  261768 1  0
r0_pos_below   1 09 140 1  42  261767 0  0
r0_neg_at      1 33 140 1 200 8118649 1  0
r0_neg_below   1 33 140 1 200 8118650 0  0
ct0_pos_at     2 12 180 1  77  261888 1  0
ct0_pos_below  2 12 180 1  77  261887 0  0
ct0_neg_at     2 2e 180 1 130 8118529 1  0
ct0_neg_below  2 2e 180 1 130 8118530 0  0
first_lane0    1 00 200 0   0  300000 1  0
lane1          1 3f 200 0 129  300000 1  0
lane2          2 1b 200 0  66 8000000 1  0
last_lane3     0 2c 200 0 255 7800000 1  0
reuse_rand_01  0 01 200 2  -1       0 1  0
reuse_rand_3f  0 3f 200 2  -1       0 1  0
outside_after  0 05 2c0 0 256 4000000 0  0
wrap_region    2 0d 3e0 0 255 7000000 1  0
abort_mid      0 11 240 0 100 5000000 0 30
after_abort    0 24 240 2  -1       0 1  0
clean_again    1 2a 300 0  -1       0 0  0

// File: dv/norm_check_tb.sv
// Testbench of the norm check, records come from dv/norm_check_stimulus.txt
// Runs from the project root, each record loads its region and runs one check
`timescale 1ns/10ps

`include "norm_check_consts.svh"

module norm_check_tb
    import mldsa_types_pkg::*;
    import norm_check_pkg::*;
();

    localparam int MAX_TESTS = 64;
    localparam int CYCLES_PER_TEST = 300;
    localparam int WORDS = `NC_WORDS_PER_POLY;
    localparam int SMALL_LIMIT = 1 << 17;
    localparam int ABORT_QUIET = 80;
    localparam logic [31:0] SEED = 32'h3e1f9058;

    logic           clk;
    logic           reset_n;
    logic           zeroize;
    logic           wr_en;
    mem_addr_t      wr_addr;
    mem_word_t      wr_data;
    logic           norm_check_enable;
    chk_norm_mode_e mode;
    rand_t          randomness;
    mem_addr_t      mem_base_addr;
    logic           norm_invalid;
    logic           done;

    logic [8*32-1:0] test_name;
    logic            expect_invalid;
    int              error_count;
    int              check_count;
    int              num_tests;
    int              expected_checks;
    int              cycle_count = 0;
    int              cycle_limit = MAX_TESTS * CYCLES_PER_TEST;

    // One entry per record of the stimulus file
    logic [8*32-1:0] rec_name [MAX_TESTS];
    int rec_mode [MAX_TESTS];
    int rec_rand [MAX_TESTS];
    int rec_base [MAX_TESTS];
    int rec_fill [MAX_TESTS];
    int rec_idx [MAX_TESTS];
    int rec_value [MAX_TESTS];
    int rec_expect [MAX_TESTS];
    int rec_abort [MAX_TESTS];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    norm_check_top norm_check_top_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .norm_invalid      (norm_invalid),
        .done              (done)
    );

    norm_check_checker norm_check_checker_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .test_name         (test_name),
        .expect_invalid    (expect_invalid),
        .norm_invalid      (norm_invalid),
        .done              (done),
        .error_count       (error_count),
        .check_count       (check_count)
    );

    function automatic int load_records();
        int    fd;
        int    count;
        int    fields;
        string line;
        count = 0;
        fd = $fopen("dv/norm_check_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/norm_check_stimulus.txt");
        end else begin
            while (!$feof(fd) && count < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %d %h %h %d %d %d %d %d", rec_name[count],
                                     rec_mode[count], rec_rand[count], rec_base[count],
                                     rec_fill[count], rec_idx[count], rec_value[count],
                                     rec_expect[count], rec_abort[count]);
                    if (fields == 9) begin
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
        return count;
    endfunction

    // Largest magnitude that still passes is one below this
    function automatic int bound_for_mode(input int m);
        case (m)
            0: return `NC_GAMMA1 - `NC_BETA;
            1: return `NC_GAMMA2 - `NC_BETA;
            default: return `NC_GAMMA2;
        endcase
    endfunction

    // Fills the 64 words from base with in-bound values, plants one coefficient
    task automatic load_region(input int t);
        mem_word_t image [WORDS+1];
        int        limit;
        int        magnitude;
        int        last;
        coef_t     coef;
        limit = (rec_fill[t] == 0) ? SMALL_LIMIT : bound_for_mode(rec_mode[t]);
        for (int w = 0; w <= WORDS; w++) begin
            for (int lane = 0; lane < `NC_LANES; lane++) begin
                magnitude = int'($urandom % limit);
                if (($urandom % 2) == 1 && magnitude != 0) begin
                    coef = coef_t'(`NC_Q - magnitude);
                end else begin
                    coef = coef_t'(magnitude);
                end
                image[w][lane*`NC_COEF_W +: `NC_COEF_W] = coef;
            end
        end
        // Index 256 and up lands in the word right after the region
        if (rec_idx[t] >= 0) begin
            image[rec_idx[t] / 4][(rec_idx[t] % 4)*`NC_COEF_W +: `NC_COEF_W] =
                coef_t'(rec_value[t]);
        end
        last = (rec_idx[t] >= `NC_N) ? WORDS : WORDS - 1;
        for (int w = 0; w <= last; w++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = mem_addr_t'(rec_base[t] + w);
            wr_data = image[w];
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_test(input int t);
        if (rec_fill[t] != 2) begin
            load_region(t);
        end
        @(negedge clk);
        test_name         = rec_name[t];
        expect_invalid    = (rec_expect[t] != 0);
        mode              = chk_norm_mode_e'(2'(rec_mode[t]));
        randomness        = rand_t'(rec_rand[t]);
        mem_base_addr     = mem_addr_t'(rec_base[t]);
        norm_check_enable = 1'b1;
        @(negedge clk);
        norm_check_enable = 1'b0;
        if (rec_abort[t] > 0) begin
            repeat (rec_abort[t] - 1) @(negedge clk);
            zeroize = 1'b1;
            @(negedge clk);
            zeroize = 1'b0;
            repeat (ABORT_QUIET) @(negedge clk);
        end else begin
            while (done !== 1'b1) @(negedge clk);
            // Lets the checker sample done before the next record changes the name
            @(negedge clk);
        end
    endtask

    initial begin
        clk               = 1'b0;
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        wr_en             = 1'b0;
        wr_addr           = '0;
        wr_data           = '0;
        norm_check_enable = 1'b0;
        mode              = CHK_Z;
        randomness        = '0;
        mem_base_addr     = '0;
        test_name         = '0;
        expect_invalid    = 1'b0;
        expected_checks   = 0;
        void'($urandom(SEED));
        num_tests = load_records();
        if (num_tests == 0) begin
            $display("No test records could be read, nothing was run");
            $display("Result: FAILED");
            $finish;
        end else begin
            cycle_limit = num_tests * CYCLES_PER_TEST;
            repeat (10) @(negedge clk);
            reset_n = 1'b1;
            for (int t = 0; t < num_tests; t++) begin
                if (rec_abort[t] == 0) begin
                    expected_checks++;
                end
                run_test(t);
            end
            repeat (4) @(negedge clk);
            $display("Closing: %0d of %0d checks completed, %0d errors",
                     check_count, expected_checks, error_count);
            if (error_count == 0 && check_count == expected_checks) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+common
common/mldsa_types_pkg.sv
common/norm_check_pkg.sv
source/coef_mem.sv
norm_check/norm_check_ctrl.sv
norm_check/norm_check_unit.sv
source/norm_check_top.sv
dv/norm_check_checker.sv
dv/norm_check_tb.sv

// File: norm_check/norm_check_ctrl.sv
// Read sequencer of the norm check, one memory word per cycle for 64 cycles
// Word order is scrambled by the randomness seed and wraps inside the address space
// A new enable is only accepted from idle
`timescale 1ns/10ps

`include "norm_check_consts.svh"

module norm_check_ctrl
    import mldsa_types_pkg::*;
    import norm_check_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,

    input  logic           norm_check_enable,
    input  chk_norm_mode_e mode,
    input  rand_t          randomness,
    input  mem_addr_t      mem_base_addr,

    output mem_addr_t      rd_addr,
    output logic           check_enable,
    output chk_norm_mode_e check_mode,
    output logic           norm_check_done
);

    localparam int OFFS_W = $clog2(`NC_WORDS_PER_POLY);

    chk_read_state_e state, state_next;

    mem_addr_t         base_addr;
    logic [OFFS_W-1:0] word_offset;
    logic [OFFS_W-2:0] upper_cnt;
    logic              low_bit;
    logic [OFFS_W-1:0] read_cnt;

    logic last_read;
    logic step_reload;

    // Offset stepping
    // In CHK_RD_MEM the low bit flips and the upper counter advances,
    // in CHK_WAIT the upper bits reload from that counter
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            base_addr   <= '0;
            check_mode  <= CHK_Z;
            word_offset <= '0;
            upper_cnt   <= '0;
            low_bit     <= 1'b0;
            read_cnt    <= '0;
        end else if (zeroize) begin
            base_addr   <= '0;
            check_mode  <= CHK_Z;
            word_offset <= '0;
            upper_cnt   <= '0;
            low_bit     <= 1'b0;
            read_cnt    <= '0;
        end else if (norm_check_enable) begin
            base_addr   <= mem_base_addr;
            check_mode  <= mode;
            word_offset <= randomness;
            upper_cnt   <= randomness[OFFS_W-1:1];
            low_bit     <= randomness[0];
            read_cnt    <= '0;
        end else if (check_enable) begin
            if (step_reload) begin
                word_offset <= {upper_cnt, low_bit};
            end else begin
                word_offset <= {word_offset[OFFS_W-1:1], ~low_bit};
                upper_cnt   <= upper_cnt + 1'b1;
            end
            read_cnt <= read_cnt + 1'b1;
        end
    end

    // Each upper value is visited with both low bits, so all 64 offsets appear once
    assign rd_addr     = base_addr + mem_addr_t'(word_offset);
    assign last_read   = (read_cnt == OFFS_W'(`NC_WORDS_PER_POLY - 1));
    assign step_reload = (state == CHK_WAIT);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= CHK_IDLE;
        end else if (zeroize) begin
            state <= CHK_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CHK_IDLE: begin
                if (norm_check_enable) begin
                    state_next = CHK_RD_MEM;
                end
            end
            CHK_RD_MEM: begin
                state_next = last_read ? CHK_DONE : CHK_WAIT;
            end
            CHK_WAIT: begin
                state_next = last_read ? CHK_DONE : CHK_RD_MEM;
            end
            CHK_DONE: begin
                state_next = CHK_IDLE;
            end
            default: begin
                state_next = CHK_IDLE;
            end
        endcase
    end

    assign check_enable    = (state == CHK_RD_MEM) || (state == CHK_WAIT);
    assign norm_check_done = (state == CHK_DONE);

    // A second enable would corrupt the running check since the sequencer has no queue
    assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        norm_check_enable |-> (state == CHK_IDLE))
        else $error("norm check enabled while busy");

    // Done closes a run of exactly 64 reads and lasts a single cycle
    assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        norm_check_done |-> $past(check_enable) &&
            $past(check_enable, `NC_WORDS_PER_POLY) &&
            !$past(check_enable, `NC_WORDS_PER_POLY + 1))
        else $error("norm check done not after exactly 64 reads");

endmodule

// File: norm_check/norm_check_unit.sv
// Bound compare of four coefficients per cycle with a sticky invalid flag
// Read data is expected one cycle after check_enable
// The invalid flag holds until the next enable and is valid with done
`timescale 1ns/10ps

`include "norm_check_consts.svh"

module norm_check_unit
    import mldsa_types_pkg::*;
    import norm_check_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,

    input  logic           norm_check_enable,
    input  logic           check_enable,
    input  chk_norm_mode_e check_mode,
    input  logic           norm_check_done,
    input  mem_word_t      rd_data,

    output logic           norm_invalid,
    output logic           done
);

    logic                 check_valid;
    coef_t                bound;
    logic [`NC_LANES-1:0] lane_over;

    // Bound for the latched mode
    always_comb begin
        case (check_mode)
            CHK_Z:   bound = coef_t'(`NC_BOUND_Z);
            CHK_R0:  bound = coef_t'(`NC_BOUND_R0);
            CHK_CT0: bound = coef_t'(`NC_BOUND_CT0);
            default: bound = coef_t'(`NC_BOUND_CT0);
        endcase
    end

    // Centered magnitude per lane
    // Values above (q-1)/2 stand for negative numbers, their magnitude is q - c
    for (genvar i = 0; i < `NC_LANES; i++) begin : g_lane
        coef_t coef;
        coef_t magnitude;

        assign coef      = rd_data[i*`NC_COEF_W +: `NC_COEF_W];
        assign magnitude = (coef <= coef_t'(`NC_HALF_Q)) ? coef
                                                          : coef_t'(`NC_Q) - coef;
        assign lane_over[i] = (magnitude >= bound);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_valid  <= 1'b0;
            norm_invalid <= 1'b0;
            done         <= 1'b0;
        end else if (zeroize) begin
            check_valid  <= 1'b0;
            norm_invalid <= 1'b0;
            done         <= 1'b0;
        end else begin
            // Lines the read request up with the returning memory word
            check_valid <= check_enable;

            // The last word is compared in the same cycle as the controller's done
            done <= norm_check_done;

            if (norm_check_enable) begin
                norm_invalid <= 1'b0;
            end else if (check_valid && (|lane_over)) begin
                norm_invalid <= 1'b1;
            end
        end
    end

    // Every word that is compared must come from a written memory location
    assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        check_valid |-> !$isunknown(rd_data))
        else $error("norm check compared unknown memory data");

endmodule

// File: source/coef_mem.sv
// Coefficient memory with one write port and one registered read port
// Read data appears one cycle after rd_en, a same-address write returns old data
`timescale 1ns/10ps

`include "norm_check_consts.svh"

module coef_mem
    import mldsa_types_pkg::*;
(
    input  logic      clk,

    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  mem_word_t wr_data,

    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output mem_word_t rd_data
);

    localparam int DEPTH = 1 << `NC_ADDR_W;

    // Storage array, no reset so it maps onto block RAM
    mem_word_t mem [0:DEPTH-1];

    // Write port, loaded from outside while the checker is idle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read
    // Nonblocking update means a colliding write is seen only on the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: source/norm_check_top.sv
// Norm check of one polynomial held in the local coefficient memory
// Writes are only allowed while no check is running
// done follows the enable edge by 66 cycles
`timescale 1ns/10ps

module norm_check_top
    import mldsa_types_pkg::*;
    import norm_check_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,

    input  logic           wr_en,
    input  mem_addr_t      wr_addr,
    input  mem_word_t      wr_data,

    input  logic           norm_check_enable,
    input  chk_norm_mode_e mode,
    input  rand_t          randomness,
    input  mem_addr_t      mem_base_addr,

    output logic           norm_invalid,
    output logic           done
);

    mem_addr_t      rd_addr;
    mem_word_t      rd_data;
    logic           check_enable;
    chk_norm_mode_e check_mode;
    logic           norm_check_done;

    coef_mem coef_mem_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (check_enable),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    norm_check_ctrl norm_check_ctrl_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .rd_addr           (rd_addr),
        .check_enable      (check_enable),
        .check_mode        (check_mode),
        .norm_check_done   (norm_check_done)
    );

    norm_check_unit norm_check_unit_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .check_enable      (check_enable),
        .check_mode        (check_mode),
        .norm_check_done   (norm_check_done),
        .rd_data           (rd_data),
        .norm_invalid      (norm_invalid),
        .done              (done)
    );

endmodule
